// ==== bench/issue_testdata.txt ====
// fetchInst  expected nextInst  expected pcNop  group (1 to 5), all hex except pcNop and group
// one line per clock after reset, fetch repeats an instruction while pcNop is expected high
d828 d828 0 1  // ALU r2 = r0, r1
4380 4380 0 1  // ADDI r4 = r3 + imm
8dc0 8dc0 0 1  // LD r6 = [r5]
8720 8720 0 1  // ST [r7] = r1
4060 4060 0 2  // ADDI r3 = r0 + imm, cycle t
db04 0800 1 2  // ALU r1 = r3, r0 blocked by r3 in D
db04 0800 1 2  // r3 in X
db04 0800 1 2  // r3 in M
db04 0800 1 2  // r3 in W
db04 db04 0 2  // issues at t+5
4060 4060 0 2  // ADDI r3 = r0 + imm again
da74 0800 1 2  // ALU r5 = r2, r3 blocked on its Rt field
da74 0800 1 2
da74 0800 1 2
da74 0800 1 2
da74 da74 0 2
88e0 88e0 0 3  // LD r7 = [r0]
81e0 0800 1 3  // ST [r1] = r7 waits on its Rd field
81e0 0800 1 3
81e0 0800 1 3
81e0 0800 1 3
81e0 81e0 0 3
4040 4040 0 3  // ADDI r2 = r0 + imm, r2 never read
dcb8 dcb8 0 3  // ALU r6 = r4, r5 no stall
6000 6000 0 4  // BEQZ r0
d930 0800 1 4  // ALU r4 = r1, r1 in branch shadow
d930 0800 1 4
d930 0800 1 4
d930 0800 1 4
d930 d930 0 4
6400 0800 1 4  // BEQZ r4 waits for r4, ignores no shadow here
6400 0800 1 4
6400 0800 1 4
6400 0800 1 4
6400 6400 0 4
0800 0800 0 5  // NOP passes inside the branch shadow
0000 0000 1 5  // HALT parks the pc
0000 0000 1 5

// ==== sim.f ====
+incdir+verilog
verilog/pipePkg.sv
verilog/instDecode.sv
verilog/hazardDet.sv
verilog/stageTrack.sv
verilog/issueStage.sv
bench/issueStage_chk.sv
bench/issueStage_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the issue stage testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
    -f sim.f --top-module issueStage_tb -o issueSim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/issueSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
exit 0

// ==== bench/issueStage_tb.sv ====
// run from the project root so the data path resolves; outputs sampled 1 ns before rising edges
`include "pipe_defines.svh"

module issueStage_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 4;
    localparam int MAX_LINES    = 256;
    // NOP opcode 00001 with operand bits zero
    localparam logic [`INST_W-1:0] BUBBLE = 16'h0800;
    // fetched words driven during reset including a halt
    localparam logic [`INST_W-1:0] RESET_PROBE [RESET_CYCLES] = '{
        16'hd828, 16'h0000, 16'h6000, 16'h8720
    };

    logic               clk = 1'b1;
    logic               reset;
    logic [`INST_W-1:0] fetchInst;
    logic [`INST_W-1:0] nextInst;
    logic               pcNop;

    // one entry per data line
    logic [`INST_W-1:0] stimInst [MAX_LINES];
    logic [`INST_W-1:0] expInst  [MAX_LINES];
    logic               expNop   [MAX_LINES];
    int                 groupId  [MAX_LINES];
    string groupName [6] = '{"reset", "independent stream", "read after write",
                             "store reads Rd", "branch shadow", "nop and halt"};
    int numLines    = 0;
    int checks      = 0;
    int errors      = 0;
    int groupChecks = 0;
    int groupErrors = 0;
    int assertFails = 0;
    bit loaded      = 1'b0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    issueStage u_dut (
        .clk       (clk),
        .reset     (reset),
        .fetchInst (fetchInst),
        .nextInst  (nextInst),
        .pcNop     (pcNop)
    );

    // reads fetchInst, expected nextInst, expected pcNop and group per line
    task automatic loadData(output bit ok);
        int                 fd;
        int                 cnt;
        string              line;
        logic [`INST_W-1:0] f;
        logic [`INST_W-1:0] e;
        logic               p;
        int                 g;
        ok = 1'b0;
        fd = $fopen("bench/issue_testdata.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd) && numLines < MAX_LINES) begin
                cnt = $fgets(line, fd);
                // comment and blank lines do not scan as four fields
                if (cnt > 0 && $sscanf(line, "%h %h %b %d", f, e, p, g) == 4) begin
                    stimInst[numLines] = f;
                    expInst[numLines]  = e;
                    expNop[numLines]   = p;
                    groupId[numLines]  = g;
                    numLines++;
                end
            end
            $fclose(fd);
            ok = (numLines > 0);
        end
    endtask

    task automatic compareOutputs(input logic [`INST_W-1:0] wantInst, input logic wantNop);
        checks++;
        groupChecks++;
        if (nextInst !== wantInst) begin
            $display("CHECK FAILED t=%0t nextInst expected %h actual %h",
                     $time, wantInst, nextInst);
            errors++;
            groupErrors++;
        end
        if (pcNop !== wantNop) begin
            $display("CHECK FAILED t=%0t pcNop expected %b actual %b", $time, wantNop, pcNop);
            errors++;
            groupErrors++;
        end
    endtask

    task automatic reportGroup(input int g);
        $display("group %0d %s: %0d checks, %0d errors", g, groupName[g], groupChecks,
                 groupErrors);
        groupChecks = 0;
        groupErrors = 0;
    endtask

    // bounded by the data length
    initial begin
        wait (loaded);
        #((RESET_CYCLES + numLines + 20) * CLK_PERIOD);
        $display("simulation timed out");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        bit ok;
        reset     = 1'b1;
        fetchInst = BUBBLE;
        loadData(ok);
        if (!ok) begin
            $display("could not read any lines from the test data file");
            $display("TEST FAILED");
            $finish;
        end else begin
            loaded = 1'b1;
            // reset held over exactly four rising edges
            for (int i = 0; i < RESET_CYCLES; i++) begin
                @(negedge clk);
                fetchInst = RESET_PROBE[i];
                #(CLK_PERIOD / 2 - 1);
                compareOutputs(BUBBLE, 1'b0);
            end
            reportGroup(0);
            for (int i = 0; i < numLines; i++) begin
                @(negedge clk);
                reset     = 1'b0;
                fetchInst = stimInst[i];
                // settle before the tracker shifts
                #(CLK_PERIOD / 2 - 1);
                compareOutputs(expInst[i], expNop[i]);
                if (i == numLines - 1 || groupId[i + 1] != groupId[i]) begin
                    reportGroup(groupId[i]);
                end
            end
            // one more edge so the checker sees the last cycle
            @(posedge clk);
            #1;
            assertFails = u_dut.uChk.failCount;
            $display("total: %0d checks, %0d errors, %0d assertion failures", checks, errors,
                     assertFails);
            if (errors == 0 && assertFails == 0) begin
                $display("TEST PASSED");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

endmodule

// ==== bench/issueStage_chk.sv ====
// sampled on rising edges only; the halt exemption looks at the opcode field alone
`include "pipe_defines.svh"

module issueStage_chk (
    input logic               clk,
    input logic               reset,
    input logic [`INST_W-1:0] fetchInst,
    input logic [`INST_W-1:0] nextInst,
    input logic               pcNop
);
    timeunit 1ns;
    timeprecision 100ps;
    import pipePkg::*;

    logic fetchHalt;
    // failed properties so far
    int   failCount = 0;

    assign fetchHalt = (fetchInst[`INST_W-1 -: `OP_W] == OP_HALT);

    // bubble out while reset is held
    resetBubble: assert property (@(posedge clk) reset |-> nextInst == `NOP_INST)
        else begin
            failCount++;
            $error("nextInst is not a bubble during reset");
        end

    resetNoHold: assert property (@(posedge clk) reset |-> !pcNop)
        else begin
            failCount++;
            $error("pcNop is high during reset");
        end

    // a held pc means a bubble unless halt is fetched
    holdMeansBubble: assert property (@(posedge clk)
            (pcNop && !fetchHalt) |-> nextInst == `NOP_INST)
        else begin
            failCount++;
            $error("pcNop is high but nextInst is not a bubble");
        end

endmodule

bind issueStage issueStage_chk uChk (
    .clk       (clk),
    .reset     (reset),
    .fetchInst (fetchInst),
    .nextInst  (nextInst),
    .pcNop     (pcNop)
);

// ==== verilog/issueStage.sv ====
// issue stage only; fetchInst must stay stable in any cycle that follows a high pcNop
`include "pipe_defines.svh"

module issueStage (
    input  logic               clk,
    input  logic               reset,
    input  logic [`INST_W-1:0] fetchInst,
    output logic [`INST_W-1:0] nextInst,
    output logic               pcNop
);
    import pipePkg::*;

    // decode results
    srcClassT          srcClass;
    logic              decRegWrt;
    logic [`REG_W-1:0] decWrtReg;
    logic              isBranch;
    logic              isHalt;
    logic              issueValid;

    // tracker state per stage
    logic              regWrtD;
    logic              regWrtX;
    logic              regWrtM;
    logic              regWrtW;
    logic [`REG_W-1:0] wrtRegD;
    logic [`REG_W-1:0] wrtRegX;
    logic [`REG_W-1:0] wrtRegM;
    logic [`REG_W-1:0] wrtRegW;
    logic              branchInstD;
    logic              branchInstX;
    logic              branchInstM;
    logic              branchInstW;

    instDecode uDecode (
        .fetchInst (fetchInst),
        .srcClass  (srcClass),
        .decRegWrt (decRegWrt),
        .decWrtReg (decWrtReg),
        .isBranch  (isBranch),
        .isHalt    (isHalt)
    );

    hazardDet uHazard (
        .reset       (reset),
        .fetchInst   (fetchInst),
        .srcClass    (srcClass),
        .isBranch    (isBranch),
        .isHalt      (isHalt),
        .regWrtD     (regWrtD),
        .regWrtX     (regWrtX),
        .regWrtM     (regWrtM),
        .regWrtW     (regWrtW),
        .wrtRegD     (wrtRegD),
        .wrtRegX     (wrtRegX),
        .wrtRegM     (wrtRegM),
        .wrtRegW     (wrtRegW),
        .branchInstD (branchInstD),
        .branchInstX (branchInstX),
        .branchInstM (branchInstM),
        .branchInstW (branchInstW),
        .nextInst    (nextInst),
        .pcNop       (pcNop),
        .issueValid  (issueValid)
    );

    stageTrack uTrack (
        .clk         (clk),
        .reset       (reset),
        .issueValid  (issueValid),
        .decRegWrt   (decRegWrt),
        .decWrtReg   (decWrtReg),
        .isBranch    (isBranch),
        .regWrtD     (regWrtD),
        .regWrtX     (regWrtX),
        .regWrtM     (regWrtM),
        .regWrtW     (regWrtW),
        .wrtRegD     (wrtRegD),
        .wrtRegX     (wrtRegX),
        .wrtRegM     (wrtRegM),
        .wrtRegW     (wrtRegW),
        .branchInstD (branchInstD),
        .branchInstX (branchInstX),
        .branchInstM (branchInstM),
        .branchInstW (branchInstW)
    );

endmodule

// ==== verilog/stageTrack.sv ====
// four-deep status pipe; wrtReg is only meaningful where the matching regWrt bit is set
`include "pipe_defines.svh"

module stageTrack (
    input  logic              clk,
    input  logic              reset,
    input  logic              issueValid,
    input  logic              decRegWrt,
    input  logic [`REG_W-1:0] decWrtReg,
    input  logic              isBranch,
    output logic              regWrtD,
    output logic              regWrtX,
    output logic              regWrtM,
    output logic              regWrtW,
    output logic [`REG_W-1:0] wrtRegD,
    output logic [`REG_W-1:0] wrtRegX,
    output logic [`REG_W-1:0] wrtRegM,
    output logic [`REG_W-1:0] wrtRegW,
    output logic              branchInstD,
    output logic              branchInstX,
    output logic              branchInstM,
    output logic              branchInstW
);

    // writer and branch flags, bubbles enter as zeros
    always_ff @(posedge clk) begin
        if (reset) begin
            regWrtD     <= 1'b0;
            regWrtX     <= 1'b0;
            regWrtM     <= 1'b0;
            regWrtW     <= 1'b0;
            branchInstD <= 1'b0;
            branchInstX <= 1'b0;
            branchInstM <= 1'b0;
            branchInstW <= 1'b0;
        end else begin
            regWrtD     <= issueValid & decRegWrt;
            regWrtX     <= regWrtD;
            regWrtM     <= regWrtX;
            regWrtW     <= regWrtM;
            branchInstD <= issueValid & isBranch;
            branchInstX <= branchInstD;
            branchInstM <= branchInstX;
            branchInstW <= branchInstM;
        end
    end

    // destination index rides along with its flag
    always_ff @(posedge clk) begin
        wrtRegD <= issueValid ? decWrtReg : '0;
        wrtRegX <= wrtRegD;
        wrtRegM <= wrtRegX;
        wrtRegW <= wrtRegM;
    end

endmodule

// ==== verilog/hazardDet.sv ====
// no forwarding: any pending writer in D..W blocks a reader; fetch must hold fetchInst on pcNop
`include "pipe_defines.svh"

module hazardDet (
    input  logic               reset,
    input  logic [`INST_W-1:0] fetchInst,
    input  pipePkg::srcClassT  srcClass,
    input  logic               isBranch,
    input  logic               isHalt,
    input  logic               regWrtD,
    input  logic               regWrtX,
    input  logic               regWrtM,
    input  logic               regWrtW,
    input  logic [`REG_W-1:0]  wrtRegD,
    input  logic [`REG_W-1:0]  wrtRegX,
    input  logic [`REG_W-1:0]  wrtRegM,
    input  logic [`REG_W-1:0]  wrtRegW,
    input  logic               branchInstD,
    input  logic               branchInstX,
    input  logic               branchInstM,
    input  logic               branchInstW,
    output logic [`INST_W-1:0] nextInst,
    output logic               pcNop,
    output logic               issueValid
);
    import pipePkg::*;

    // stage views, index 0 is D, 3 is W
    logic [3:0]            stgWrt;
    logic [4*`REG_W-1:0]   stgReg;
    logic                  rsHit;
    logic                  secHit;
    logic                  branchShadow;
    logic                  stall;

    // true when some stage will still write fld
    function automatic logic regBusy(input logic [`REG_W-1:0] fld, input logic [3:0] wrt,
                                     input logic [4*`REG_W-1:0] regs);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (wrt[i] && (regs[i*`REG_W +: `REG_W] == fld)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    assign stgWrt = {regWrtW, regWrtM, regWrtX, regWrtD};
    assign stgReg = {wrtRegW, wrtRegM, wrtRegX, wrtRegD};

    assign rsHit  = regBusy(fetchInst[10:8], stgWrt, stgReg);
    assign secHit = regBusy(fetchInst[7:5], stgWrt, stgReg);

    // unresolved branch anywhere downstream
    assign branchShadow = branchInstD | branchInstX | branchInstM | branchInstW;

    always_comb begin
        case (srcClass)
            // branches ignore the shadow of older branches
            SRC_RS:        stall = isBranch ? rsHit : (rsHit | branchShadow);
            SRC_RS_SECOND: stall = rsHit | secHit | branchShadow;
            // halt and nop never wait
            default:       stall = 1'b0;
        endcase
    end

    always_comb begin
        if (reset) begin
            nextInst   = `NOP_INST;
            pcNop      = 1'b0;
            issueValid = 1'b0;
        end else if (isHalt) begin
            // halt parks the pc and keeps showing itself
            nextInst   = fetchInst;
            pcNop      = 1'b1;
            issueValid = 1'b0;
        end else if (stall) begin
            nextInst   = `NOP_INST;
            pcNop      = 1'b1;
            issueValid = 1'b0;
        end else begin
            nextInst   = fetchInst;
            pcNop      = 1'b0;
            issueValid = 1'b1;
        end
    end

endmodule

// ==== verilog/instDecode.sv ====
// pure decode of inst[15:11]; unlisted opcodes are treated as Rs readers that write nothing
`include "pipe_defines.svh"

module instDecode (
    input  logic [`INST_W-1:0] fetchInst,
    output pipePkg::srcClassT  srcClass,
    output logic               decRegWrt,
    output logic [`REG_W-1:0]  decWrtReg,
    output logic               isBranch,
    output logic               isHalt
);
    import pipePkg::*;

    opcodeT            op;
    logic [`REG_W-1:0] rsFld;
    logic [`REG_W-1:0] midFld;
    logic [`REG_W-1:0] lowFld;

    assign op     = opcodeT'(fetchInst[`INST_W-1 -: `OP_W]);
    assign rsFld  = fetchInst[10:8];
    // Rd of I-format, Rt of R-format
    assign midFld = fetchInst[7:5];
    // Rd of R-format
    assign lowFld = fetchInst[4:2];

    always_comb begin
        // most opcodes read only Rs and write nothing
        srcClass  = SRC_RS;
        decRegWrt = 1'b0;
        decWrtReg = rsFld;
        isBranch  = 1'b0;
        isHalt    = 1'b0;
        casez (op)
            OP_HALT: begin
                srcClass = SRC_NONE;
                isHalt   = 1'b1;
            end
            // nop group, no operands
            5'b0_00??: srcClass = SRC_NONE;
            // branch group, same shape as OP_BEQZ
            5'b0_11??: isBranch = 1'b1;
            // immediate group of OP_ADDI
            5'b0_10??: begin
                decRegWrt = 1'b1;
                decWrtReg = midFld;
            end
            OP_ST: srcClass = SRC_RS_SECOND;
            OP_LD: begin
                decRegWrt = 1'b1;
                decWrtReg = midFld;
            end
            // store with update writes back Rs
            OP_STU: begin
                srcClass  = SRC_RS_SECOND;
                decRegWrt = 1'b1;
                decWrtReg = rsFld;
            end
            OP_BITOP, OP_ALU, 5'b1_11??: begin
                srcClass  = SRC_RS_SECOND;
                decRegWrt = 1'b1;
                decWrtReg = lowFld;
            end
            default: ;
        endcase
    end

endmodule

// ==== verilog/pipePkg.sv ====
// enums cover only the opcode groups the issue stage decodes; jumps are not modelled
`include "pipe_defines.svh"

package pipePkg;

    // major opcodes, inst[15:11]
    // OP_BEQZ and OP_SET each stand for a whole 011xx / 111xx group
    typedef enum logic [`OP_W-1:0] {
        OP_HALT  = 5'b0_0000,
        OP_NOP   = 5'b0_0001,
        OP_ADDI  = 5'b0_1000,
        OP_BEQZ  = 5'b0_1100,
        OP_ST    = 5'b1_0000,
        OP_LD    = 5'b1_0001,
        OP_STU   = 5'b1_0011,
        OP_BITOP = 5'b1_1010,
        OP_ALU   = 5'b1_1011,
        OP_SET   = 5'b1_1100
    } opcodeT;

    // which register fields an instruction reads
    // SRC_RS_SECOND: Rs plus the bits 7..5 field (Rd of a store, Rt of an ALU op)
    typedef enum logic [1:0] {
        SRC_NONE,
        SRC_RS,
        SRC_RS_SECOND
    } srcClassT;

endpackage

// ==== verilog/pipe_defines.svh ====
// widths fixed for the 16-bit teaching ISA; opcode must stay in the top five bits
`ifndef PIPE_DEFINES_SVH
`define PIPE_DEFINES_SVH

// full instruction word
`define INST_W 16

// major opcode, bits 15 to 11
`define OP_W 5

// register index, eight registers
`define REG_W 3

// bubble: NOP opcode with all operand bits zero
`define NOP_INST {5'b0_0001, {(`INST_W - `OP_W){1'b0}}}

`endif
